// ==== source/abacus_pkg.sv ====
package abacus_pkg;

	// Bus and counter widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int INSTR_W = 32;

	// Number of counted instruction classes and cache counters
	localparam int NUM_CLASSES = 11;
	localparam int NUM_CACHE_COUNTERS = 8;

	// Register offsets from the base address
	localparam logic [ADDR_W-1:0] INSTR_ENABLE_OFS = 32'h0000_0004;
	localparam logic [ADDR_W-1:0] CACHE_ENABLE_OFS = 32'h0000_0008;
	localparam logic [ADDR_W-1:0] INSTR_COUNTER_OFS = 32'h0000_0100;
	localparam logic [ADDR_W-1:0] CACHE_COUNTER_OFS = 32'h0000_0200;

	// RISC-V major opcodes, instruction bits 6:0
	typedef enum logic [6:0] {
		OPC_LOAD = 7'b0000011,
		OPC_STORE = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP = 7'b0110011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL = 7'b1101111,
		OPC_JALR = 7'b1100111,
		OPC_SYSTEM = 7'b1110011,
		OPC_AMO = 7'b0101111
	} opcode_e;

	// Profiling classes, the value is also the counter index
	typedef enum logic [3:0] {
		LOAD_WORD = 4'd0,
		STORE_WORD = 4'd1,
		ADDITION = 4'd2,
		SUBTRACTION = 4'd3,
		LOGICAL = 4'd4,
		SHIFT = 4'd5,
		COMPARISON = 4'd6,
		BRANCH = 4'd7,
		JUMP = 4'd8,
		SYSTEM_PRIV = 4'd9,
		ATOMIC = 4'd10,
		CLASS_NONE = 4'd15
	} instr_class_e;

	// One counter per class, indexed by class value
	typedef logic [NUM_CLASSES-1:0][DATA_W-1:0] instr_counts_t;

	// Cache counters in register map order, ic_request first
	typedef struct packed {
		logic [DATA_W-1:0] ic_request;
		logic [DATA_W-1:0] ic_hit;
		logic [DATA_W-1:0] ic_miss;
		logic [DATA_W-1:0] ic_fill;
		logic [DATA_W-1:0] dc_request;
		logic [DATA_W-1:0] dc_hit;
		logic [DATA_W-1:0] dc_miss;
		logic [DATA_W-1:0] dc_fill;
	} cache_counts_t;

	// Event inputs from the two caches
	typedef struct packed {
		logic ic_request;
		logic ic_miss;
		logic ic_fill_busy;
		logic dc_request;
		logic dc_hit;
		logic dc_fill_busy;
	} cache_events_t;

	// Wishbone master request
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

endpackage

// ==== source/abacus_regs.sv ====
`timescale 1ns/1ps

module abacus_regs
	import abacus_pkg::*;
#(
	parameter logic [ADDR_W-1:0] ABACUS_BASE_ADDR = 32'hF003_0000
)
(
	input logic S_AXI_ACLK,
	input logic rst,
	input wb_req_t wb_req_i,
	output logic [DATA_W-1:0] wb_dat_o,
	output logic wb_ack_o,
	input instr_counts_t instr_counts_i,
	input cache_counts_t cache_counts_i,
	output logic instr_en_o,
	output logic cache_en_o
);

	localparam logic [ADDR_W-1:0] INSTR_EN_ADDR = ABACUS_BASE_ADDR + INSTR_ENABLE_OFS;
	localparam logic [ADDR_W-1:0] CACHE_EN_ADDR = ABACUS_BASE_ADDR + CACHE_ENABLE_OFS;
	localparam logic [ADDR_W-1:0] INSTR_CNT_ADDR = ABACUS_BASE_ADDR + INSTR_COUNTER_OFS;
	localparam logic [ADDR_W-1:0] CACHE_CNT_ADDR = ABACUS_BASE_ADDR + CACHE_COUNTER_OFS;
	localparam int INSTR_IDX_W = $clog2(NUM_CLASSES);
	localparam int CACHE_IDX_W = $clog2(NUM_CACHE_COUNTERS);

	logic access;
	logic first_edge;
	logic ack_q;
	logic [DATA_W-1:0] instr_en_q;
	logic [DATA_W-1:0] cache_en_q;
	logic [ADDR_W-1:0] instr_ofs;
	logic [ADDR_W-1:0] cache_ofs;
	logic instr_hit;
	logic cache_hit;
	logic [INSTR_IDX_W-1:0] instr_idx;
	logic [CACHE_IDX_W-1:0] cache_idx;
	logic [DATA_W-1:0] rd_data;

	assign access = wb_req_i.cyc & wb_req_i.stb;
	// Access is new when no acknowledge is pending
	assign first_edge = access & ~ack_q;

	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			ack_q <= 1'b0;
			instr_en_q <= '0;
			cache_en_q <= '0;
		end
		else
		begin
			ack_q <= first_edge;
			if (first_edge && wb_req_i.we)
			begin
				if (wb_req_i.adr == INSTR_EN_ADDR)
					instr_en_q <= wb_req_i.dat;
				else if (wb_req_i.adr == CACHE_EN_ADDR)
					cache_en_q <= wb_req_i.dat;
			end
		end
	end

	// Counter windows are word aligned and bounded by the counter count
	assign instr_ofs = wb_req_i.adr - INSTR_CNT_ADDR;
	assign cache_ofs = wb_req_i.adr - CACHE_CNT_ADDR;
	assign instr_hit = (instr_ofs[1:0] == 2'b00) &&
		(instr_ofs[ADDR_W-1:2] < (ADDR_W-2)'(NUM_CLASSES));
	assign cache_hit = (cache_ofs[1:0] == 2'b00) &&
		(cache_ofs[ADDR_W-1:2] < (ADDR_W-2)'(NUM_CACHE_COUNTERS));
	assign instr_idx = instr_ofs[INSTR_IDX_W+1:2];
	assign cache_idx = cache_ofs[CACHE_IDX_W+1:2];

	always_comb
	begin
		rd_data = '0;
		if (access && !wb_req_i.we)
		begin
			if (wb_req_i.adr == INSTR_EN_ADDR)
				rd_data = instr_en_q;
			else if (wb_req_i.adr == CACHE_EN_ADDR)
				rd_data = cache_en_q;
			else if (instr_hit)
				rd_data = instr_counts_i[instr_idx];
			else if (cache_hit)
			begin
				case (cache_idx)
					3'd0: rd_data = cache_counts_i.ic_request;
					3'd1: rd_data = cache_counts_i.ic_hit;
					3'd2: rd_data = cache_counts_i.ic_miss;
					3'd3: rd_data = cache_counts_i.ic_fill;
					3'd4: rd_data = cache_counts_i.dc_request;
					3'd5: rd_data = cache_counts_i.dc_hit;
					3'd6: rd_data = cache_counts_i.dc_miss;
					default: rd_data = cache_counts_i.dc_fill;
				endcase
			end
		end
	end

	assign wb_dat_o = rd_data;
	assign wb_ack_o = ack_q;
	assign instr_en_o = instr_en_q[0];
	assign cache_en_o = cache_en_q[0];

endmodule

// ==== source/instr_classifier.sv ====
`timescale 1ns/1ps

module instr_classifier
	import abacus_pkg::*;
(
	input logic [INSTR_W-1:0] instr_i,
	output instr_class_e class_o
);

	opcode_e opcode;
	logic [2:0] funct3;
	logic alt_bit;

	assign opcode = opcode_e'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	// Bit 30 separates sub from add in register-register ops
	assign alt_bit = instr_i[30];

	always_comb
	begin
		class_o = CLASS_NONE;
		case (opcode)
			OPC_LOAD: class_o = LOAD_WORD;
			OPC_STORE: class_o = STORE_WORD;
			OPC_BRANCH: class_o = BRANCH;
			OPC_JAL,
			OPC_JALR: class_o = JUMP;
			OPC_SYSTEM: class_o = SYSTEM_PRIV;
			OPC_AMO: class_o = ATOMIC;
			OPC_OP,
			OPC_OP_IMM:
			begin
				case (funct3)
					3'b000:
					begin
						if (opcode == OPC_OP && alt_bit)
							class_o = SUBTRACTION;
						else
							class_o = ADDITION;
					end
					3'b100,
					3'b110,
					3'b111: class_o = LOGICAL;
					3'b001,
					3'b101: class_o = SHIFT;
					default: class_o = COMPARISON;
				endcase
			end
			// LUI, AUIPC, fences and the like are not counted
			default: class_o = CLASS_NONE;
		endcase
	end

endmodule

// ==== source/instr_profiler.sv ====
`timescale 1ns/1ps

module instr_profiler
	import abacus_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic rst,
	input logic en_i,
	input logic issued_i,
	input instr_class_e class_i,
	output instr_counts_t counts_o
);

	instr_counts_t counts_q;
	logic count_en;

	// Only counted classes take part
	assign count_en = en_i & issued_i & (class_i != CLASS_NONE);

	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			counts_q <= '0;
		end
		else if (count_en)
		begin
			for (int k = 0; k < NUM_CLASSES; k++)
			begin
				if (class_i == instr_class_e'(k))
					counts_q[k] <= counts_q[k] + DATA_W'(1);
			end
		end
	end

	assign counts_o = counts_q;

endmodule

// ==== source/cache_profiler.sv ====
`timescale 1ns/1ps

module cache_profiler
	import abacus_pkg::*;
(
	input logic S_AXI_ACLK,
	input logic rst,
	input logic en_i,
	input cache_events_t ev_i,
	output cache_counts_t counts_o
);

	logic ic_hit;
	logic ic_miss;
	logic dc_hit;
	logic dc_miss;
	logic [NUM_CACHE_COUNTERS-1:0] inc;
	logic [NUM_CACHE_COUNTERS-1:0][DATA_W-1:0] cnt_q;

	// Icache reports misses, dcache reports hits
	assign ic_miss = ev_i.ic_request & ev_i.ic_miss;
	assign ic_hit = ev_i.ic_request & ~ev_i.ic_miss;
	assign dc_hit = ev_i.dc_request & ev_i.dc_hit;
	assign dc_miss = ev_i.dc_request & ~ev_i.dc_hit;

	// MSB first so the vector lines up with cache_counts_t
	assign inc = {
		ev_i.ic_request,
		ic_hit,
		ic_miss,
		ev_i.ic_fill_busy,
		ev_i.dc_request,
		dc_hit,
		dc_miss,
		ev_i.dc_fill_busy
	};

	always_ff @(posedge S_AXI_ACLK or posedge rst)
	begin
		if (rst)
		begin
			cnt_q <= '0;
		end
		else if (en_i)
		begin
			for (int i = 0; i < NUM_CACHE_COUNTERS; i++)
			begin
				if (inc[i])
					cnt_q[i] <= cnt_q[i] + DATA_W'(1);
			end
		end
	end

	assign counts_o = cache_counts_t'(cnt_q);

endmodule

// ==== source/abacus_top.sv ====
`timescale 1ns/1ps

module abacus_top
	import abacus_pkg::*;
#(
	parameter logic [ADDR_W-1:0] ABACUS_BASE_ADDR = 32'hF003_0000
)
(
	input logic S_AXI_ACLK,
	input logic rst,
	input wb_req_t wb_req_i,
	output logic [DATA_W-1:0] wb_dat_o,
	output logic wb_ack_o,
	input logic [INSTR_W-1:0] instr_i,
	input logic instr_issued_i,
	input cache_events_t cache_ev_i
);

	logic instr_en;
	logic cache_en;
	instr_class_e instr_class;
	instr_counts_t instr_counts;
	cache_counts_t cache_counts;

	abacus_regs #(
		.ABACUS_BASE_ADDR(ABACUS_BASE_ADDR)
	) u_regs (
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.wb_req_i(wb_req_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.instr_counts_i(instr_counts),
		.cache_counts_i(cache_counts),
		.instr_en_o(instr_en),
		.cache_en_o(cache_en)
	);

	instr_classifier u_classifier (
		.instr_i(instr_i),
		.class_o(instr_class)
	);

	instr_profiler u_instr_prof (
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.en_i(instr_en),
		.issued_i(instr_issued_i),
		.class_i(instr_class),
		.counts_o(instr_counts)
	);

	cache_profiler u_cache_prof (
		.S_AXI_ACLK(S_AXI_ACLK),
		.rst(rst),
		.en_i(cache_en),
		.ev_i(cache_ev_i),
		.counts_o(cache_counts)
	);

endmodule

// ==== dv/abacus_tb.sv ====
`timescale 1ns/1ps

module abacus_tb
	import abacus_pkg::*;
();

	localparam logic [ADDR_W-1:0] BASE = 32'hF003_0000;
	localparam int CLK_PERIOD = 40;
	// Generous estimate of all test cycles, the watchdog allows twice that
	localparam int EST_CYCLES = 5000;
	localparam logic [ADDR_W-1:0] UNMAPPED [6] = '{
		BASE + 32'h000, BASE + 32'h00C, BASE + 32'h102,
		BASE + 32'h12C, BASE + 32'h220, 32'hF004_0004
	};

	// One row of the opcode and funct3 table
	typedef struct packed {
		logic [6:0] op;
		logic [2:0] f3;
		logic b30;
		instr_class_e cls;
	} recipe_t;

	logic clk;
	logic rst;
	wb_req_t wb_req;
	logic [DATA_W-1:0] wb_dat;
	logic wb_ack;
	logic [INSTR_W-1:0] instr;
	logic issued;
	cache_events_t cache_ev;

	logic [DATA_W-1:0] instr_model [NUM_CLASSES];
	cache_counts_t cache_model;
	int ack_count;
	int access_count;

	abacus_top dut (
		.S_AXI_ACLK(clk),
		.rst(rst),
		.wb_req_i(wb_req),
		.wb_dat_o(wb_dat),
		.wb_ack_o(wb_ack),
		.instr_i(instr),
		.instr_issued_i(issued),
		.cache_ev_i(cache_ev)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Every acknowledge cycle on the bus
	always @(negedge clk)
	begin
		if (wb_ack)
			ack_count++;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_word(input string test, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp)
			stop_with_failure($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
				test, exp, act));
	endtask

	task automatic bus_cycle(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we <= we;
		wb_req.adr <= adr;
		wb_req.dat <= wdat;
		access_count++;
		do
		begin
			@(negedge clk);
			waited++;
			if (waited > 8)
				stop_with_failure($sformatf("No acknowledge for the access to 0x%08h", adr));
		end
		while (!wb_ack);
		rdat = wb_dat;
		@(posedge clk);
		wb_req <= '0;
		// Request was still high at this edge, ack must drop anyway
		@(negedge clk);
		if (wb_ack)
			stop_with_failure($sformatf("Acknowledge held a second cycle at 0x%08h", adr));
	endtask

	task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
		logic [DATA_W-1:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] dat);
		bus_cycle(1'b0, adr, '0, dat);
	endtask

	task automatic expect_read(input string test, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] got;
		wb_read(adr, got);
		check_word(test, exp, got);
	endtask

	// Reads the counter that the class selects and compares it with the model
	task automatic check_class(input string test, input instr_class_e cls,
		input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] got;
		wb_read(BASE + INSTR_COUNTER_OFS + (ADDR_W'(cls) << 2), got);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %s: class %s expected %0d, actual %0d",
				test, cls.name(), exp, got));
	endtask

	task automatic check_instr_counters(input string test);
		for (int k = 0; k < NUM_CLASSES; k++)
			check_class(test, instr_class_e'(k), instr_model[k]);
	endtask

	task automatic check_cache_counters(input string test);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h00, cache_model.ic_request);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h04, cache_model.ic_hit);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h08, cache_model.ic_miss);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h0C, cache_model.ic_fill);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h10, cache_model.dc_request);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h14, cache_model.dc_hit);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h18, cache_model.dc_miss);
		expect_read(test, BASE + CACHE_COUNTER_OFS + 32'h1C, cache_model.dc_fill);
	endtask

	// Builds a random instruction from one table row, the row gives the class
	function automatic logic [INSTR_W-1:0] make_instr(input int sel, output instr_class_e cls);
		logic [31:0] r;
		logic [6:0] alu_op;
		recipe_t rec;
		r = $urandom;
		alu_op = r[7] ? OPC_OP : OPC_OP_IMM;
		case (sel)
			0: rec = '{OPC_LOAD, r[14:12], r[30], LOAD_WORD};
			1: rec = '{OPC_STORE, r[14:12], r[30], STORE_WORD};
			2: rec = '{OPC_OP_IMM, 3'b000, r[30], ADDITION};
			3: rec = '{OPC_OP, 3'b000, 1'b0, ADDITION};
			4: rec = '{OPC_OP, 3'b000, 1'b1, SUBTRACTION};
			5: rec = '{alu_op, 3'b100, r[30], LOGICAL};
			6: rec = '{alu_op, 3'b110, r[30], LOGICAL};
			7: rec = '{alu_op, 3'b111, r[30], LOGICAL};
			8: rec = '{alu_op, 3'b001, r[30], SHIFT};
			9: rec = '{alu_op, 3'b101, r[30], SHIFT};
			10: rec = '{alu_op, 3'b010, r[30], COMPARISON};
			11: rec = '{alu_op, 3'b011, r[30], COMPARISON};
			12: rec = '{OPC_BRANCH, r[14:12], r[30], BRANCH};
			13: rec = '{OPC_JAL, r[14:12], r[30], JUMP};
			14: rec = '{OPC_JALR, r[14:12], r[30], JUMP};
			15: rec = '{OPC_SYSTEM, r[14:12], r[30], SYSTEM_PRIV};
			16: rec = '{OPC_AMO, r[14:12], r[30], ATOMIC};
			// LUI, AUIPC and FENCE are not counted
			17: rec = '{7'b0110111, r[14:12], r[30], CLASS_NONE};
			18: rec = '{7'b0010111, r[14:12], r[30], CLASS_NONE};
			default: rec = '{7'b0001111, r[14:12], r[30], CLASS_NONE};
		endcase
		cls = rec.cls;
		return {r[31], rec.b30, r[29:15], rec.f3, r[11:7], rec.op};
	endfunction

	task automatic issue_instrs(input int count, input logic issue, input logic counted);
		instr_class_e cls;
		logic [INSTR_W-1:0] ins;
		repeat (count)
		begin
			ins = make_instr(int'($urandom_range(0, 19)), cls);
			@(posedge clk);
			instr <= ins;
			issued <= issue;
			if (issue && counted && cls != CLASS_NONE)
				instr_model[cls] = instr_model[cls] + DATA_W'(1);
			// Gap cycles show other instructions with no issue strobe
			repeat ($urandom_range(0, 2))
			begin
				@(posedge clk);
				instr <= $urandom;
				issued <= 1'b0;
			end
		end
		@(posedge clk);
		issued <= 1'b0;
	endtask

	task automatic drive_events(input int cycles, input logic counted);
		logic [31:0] r;
		cache_events_t ev;
		repeat (cycles)
		begin
			r = $urandom;
			ev = r[5:0];
			@(posedge clk);
			cache_ev <= ev;
			if (counted)
			begin
				cache_model.ic_request += DATA_W'(ev.ic_request);
				cache_model.ic_hit += DATA_W'(ev.ic_request & ~ev.ic_miss);
				cache_model.ic_miss += DATA_W'(ev.ic_request & ev.ic_miss);
				cache_model.ic_fill += DATA_W'(ev.ic_fill_busy);
				cache_model.dc_request += DATA_W'(ev.dc_request);
				cache_model.dc_hit += DATA_W'(ev.dc_request & ev.dc_hit);
				cache_model.dc_miss += DATA_W'(ev.dc_request & ~ev.dc_hit);
				cache_model.dc_fill += DATA_W'(ev.dc_fill_busy);
			end
		end
		@(posedge clk);
		cache_ev <= '0;
	endtask

	task automatic test_reset_map();
		string t;
		t = "test_reset_map";
		expect_read(t, BASE + INSTR_ENABLE_OFS, '0);
		expect_read(t, BASE + CACHE_ENABLE_OFS, '0);
		check_instr_counters(t);
		check_cache_counters(t);
		wb_write(BASE + INSTR_ENABLE_OFS, 32'hA5A5_0001);
		wb_write(BASE + CACHE_ENABLE_OFS, 32'hA5A5_0001);
		expect_read(t, BASE + INSTR_ENABLE_OFS, 32'hA5A5_0001);
		expect_read(t, BASE + CACHE_ENABLE_OFS, 32'hA5A5_0001);
		foreach (UNMAPPED[i])
		begin
			wb_write(UNMAPPED[i], 32'hFFFF_FFFF);
			expect_read(t, UNMAPPED[i], '0);
		end
		expect_read(t, BASE + INSTR_ENABLE_OFS, 32'hA5A5_0001);
		expect_read(t, BASE + CACHE_ENABLE_OFS, 32'hA5A5_0001);
		wb_write(BASE + INSTR_ENABLE_OFS, '0);
		wb_write(BASE + CACHE_ENABLE_OFS, '0);
		check_instr_counters(t);
		check_word(t, DATA_W'(access_count), DATA_W'(ack_count));
	endtask

	task automatic test_instr_classes();
		wb_write(BASE + INSTR_ENABLE_OFS, 32'h0000_0001);
		issue_instrs(200, 1'b1, 1'b1);
		wb_write(BASE + INSTR_ENABLE_OFS, '0);
		check_instr_counters("test_instr_classes");
	endtask

	task automatic test_instr_gating();
		wb_write(BASE + INSTR_ENABLE_OFS, 32'hFFFF_FFFE);
		issue_instrs(50, 1'b1, 1'b0);
		wb_write(BASE + INSTR_ENABLE_OFS, 32'h0000_0001);
		issue_instrs(50, 1'b0, 1'b0);
		wb_write(BASE + INSTR_ENABLE_OFS, '0);
		check_instr_counters("test_instr_gating");
	endtask

	task automatic test_cache_events();
		wb_write(BASE + CACHE_ENABLE_OFS, 32'h0000_0001);
		drive_events(300, 1'b1);
		wb_write(BASE + CACHE_ENABLE_OFS, '0);
		check_cache_counters("test_cache_events");
	endtask

	task automatic test_cache_gating();
		wb_write(BASE + CACHE_ENABLE_OFS, '0);
		drive_events(100, 1'b0);
		check_cache_counters("test_cache_gating");
		check_instr_counters("test_cache_gating");
	endtask

	initial
	begin
		void'($urandom(99));
		rst = 1'b1;
		wb_req = '0;
		instr = '0;
		issued = 1'b0;
		cache_ev = '0;
		ack_count = 0;
		access_count = 0;
		cache_model = '0;
		foreach (instr_model[k])
			instr_model[k] = '0;
		repeat (5)
			@(posedge clk);
		rst <= 1'b0;
		test_reset_map();
		test_instr_classes();
		test_instr_gating();
		test_cache_events();
		test_cache_gating();
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial
	begin
		#(2 * EST_CYCLES * CLK_PERIOD);
		stop_with_failure("Watchdog timeout, the tests did not finish in time");
	end

endmodule

// ==== project.f ====
source/abacus_pkg.sv
source/abacus_regs.sv
source/instr_classifier.sv
source/instr_profiler.sv
source/cache_profiler.sv
source/abacus_top.sv
dv/abacus_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the abacus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f project.f --top-module abacus_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vabacus_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
